//--- hdl/mac_consts.svh
// widths and limits of the 32-bit MAC datapath
// the window select only shifts up to 48 and the range check only up to 47
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// width of the multiplier and coefficient operands
`define MAC_OPER_W 32

// operands carry a quarter of their width again as guard bits
`define MAC_EXT_W 40

// the accumulator holds the full product of two extended operands
`define MAC_ACC_W 80

// width of the presented output window
`define MAC_OUT_W 32

// width of the window select input
`define MAC_SEL_W 6

// largest shift of the output window, larger selects read as 0
`define MAC_SEL_MAX 48

// largest shift that still gets its own range check
`define MAC_SAT_SEL_MAX 47

`endif

//--- hdl/mac_pkg.sv
// datapath types of the MAC, all unsigned vectors
// signed arithmetic is done with explicit casts where it is needed
`include "mac_consts.svh"

`default_nettype none

package mac_pkg;

  // one multiplier or coefficient operand as presented at the top level
  typedef logic [`MAC_OPER_W-1:0] oper_t;

  // an operand after sign or zero extension into the guard bits
  typedef logic [`MAC_EXT_W-1:0] ext_t;

  // a full accumulator value
  // this is also the width of the product and of the addend
  typedef logic [`MAC_ACC_W-1:0] acc_t;

  // the output word taken out of the accumulator window
  typedef logic [`MAC_OUT_W-1:0] out_t;

  // window select, also used to place the round constant
  typedef logic [`MAC_SEL_W-1:0] sel_t;

endpackage

`default_nettype wire

//--- hdl/mac_multiply_add.sv
// purely combinational multiply-add, no pipeline stage inside
// the sum wraps modulo 2**80, there is no overflow flag
`timescale 1ns/1ps
`default_nettype none

`include "mac_consts.svh"

module mac_multiply_add (
  input  wire mac_pkg::oper_t oper_data,
  input  wire mac_pkg::oper_t coef_data,
  input  wire logic           tc,
  input  wire mac_pkg::acc_t  addend,
  output mac_pkg::acc_t       sum
);

  // number of guard bits added above each operand
  localparam int GUARD_W = `MAC_EXT_W - `MAC_OPER_W;

  mac_pkg::ext_t oper_ext;
  mac_pkg::ext_t coef_ext;
  logic          oper_fill;
  logic          coef_fill;
  mac_pkg::acc_t product;

  // in two's complement mode the guard bits copy the operand sign
  // in unsigned mode they are zero, so the extended value stays positive
  assign oper_fill = tc & oper_data[`MAC_OPER_W-1];
  assign coef_fill = tc & coef_data[`MAC_OPER_W-1];

  assign oper_ext = {{GUARD_W{oper_fill}}, oper_data};
  assign coef_ext = {{GUARD_W{coef_fill}}, coef_data};

  // both extended operands are read as signed numbers
  // an unsigned operand has a zero top bit after extension, so one signed
  // multiplier covers both modes
  // the 80-bit target widens the operands before the multiply, which keeps
  // the product exact for every 40-bit input pair
  assign product = $signed(oper_ext) * $signed(coef_ext);

  // the addend comes from the accumulator feedback or a restart constant
  // adding modulo 2**80 is the same for signed and unsigned sums
  assign sum = product + addend;

endmodule

`default_nettype wire

//--- hdl/mac_acc_register.sv
// accumulator register with clear and round restart on enabled edges only
// the round constant follows the live out_sel, not the registered one
`timescale 1ns/1ps
`default_nettype none

`include "mac_consts.svh"

module mac_acc_register (
  input  wire logic          MAC_ACC_CLK,
  input  wire logic          acc_ff_rstn,
  input  wire logic          clk_en,
  input  wire logic          acc_clear,
  input  wire logic          acc_rnd,
  input  wire mac_pkg::sel_t out_sel,
  input  wire mac_pkg::acc_t sum,
  output mac_pkg::acc_t      addend,
  output mac_pkg::acc_t      acc
);

  mac_pkg::acc_t round_value;
  logic          round_sel_ok;

  // rounding adds half an LSB of the selected output window
  // a shift of 0 has no half LSB, and shifts above 48 select no window
  assign round_sel_ok = (out_sel != '0) && (out_sel <= `MAC_SEL_MAX);

  always_comb begin
    round_value = '0;
    if (round_sel_ok) begin
      round_value = mac_pkg::acc_t'(1) << (out_sel - 1'b1);
    end
  end

  // clear wins over round, and round wins over the normal feedback
  // both restart the sum, so the old accumulator is dropped
  always_comb begin
    if (acc_clear) begin
      addend = '0;
    end else if (acc_rnd) begin
      addend = round_value;
    end else begin
      addend = acc;
    end
  end

  // the accumulator only moves on enabled edges
  // with clk_en low it keeps its value and the addend is ignored
  always_ff @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      acc <= '0;
    end else if (clk_en) begin
      acc <= sum;
    end
  end

  // a disabled edge must leave the accumulator as it was, whatever the
  // multiply-add presents on sum
  a_hold_when_disabled : assert property (
    @(posedge MAC_ACC_CLK) disable iff (!acc_ff_rstn)
    !clk_en |=> $stable(acc)
  ) else $error("accumulator changed on an edge with clk_en low");

endmodule

`default_nettype wire

//--- hdl/mac_output_stage.sv
// output window and saturation, combinational from acc, tc and acc_sat
// out_sel is used one edge late, to line up with the accumulator it selects
`timescale 1ns/1ps
`default_nettype none

`include "mac_consts.svh"

module mac_output_stage (
  input  wire logic          MAC_ACC_CLK,
  input  wire logic          acc_ff_rstn,
  input  wire mac_pkg::sel_t out_sel,
  input  wire mac_pkg::acc_t acc,
  input  wire logic          tc,
  input  wire logic          acc_sat,
  output mac_pkg::out_t      mac_out
);

  mac_pkg::sel_t sel_q;
  mac_pkg::sel_t win_shift;
  mac_pkg::sel_t chk_shift;
  mac_pkg::acc_t win_full;
  mac_pkg::out_t window;
  mac_pkg::acc_t sign_mask;
  mac_pkg::acc_t zero_mask;
  mac_pkg::acc_t sign_bits;
  logic          fits_signed;
  logic          fits_unsigned;
  logic          fits;
  mac_pkg::out_t clamp_word;

  // the select is sampled on every edge, enabled or not
  // so a new window shows up one edge after out_sel changes, even on hold
  always_ff @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      sel_q <= '0;
    end else begin
      sel_q <= out_sel;
    end
  end

  // selects past the largest shift fall back to the low window
  assign win_shift = (sel_q > `MAC_SEL_MAX) ? '0 : sel_q;

  // the range check has one step less, 48 is checked like 0
  assign chk_shift = (sel_q > `MAC_SAT_SEL_MAX) ? '0 : sel_q;

  assign win_full = acc >> win_shift;
  assign window   = win_full[`MAC_OUT_W-1:0];

  // sign_mask covers the window MSB and every bit above it
  // the window fits as a signed word when all of these bits agree
  assign sign_mask = {`MAC_ACC_W{1'b1}} << (chk_shift + (`MAC_OUT_W - 1));
  assign sign_bits = acc & sign_mask;

  assign fits_signed = (sign_bits == sign_mask) || (sign_bits == '0);

  // an unsigned sum also fits with a set window MSB, as long as nothing
  // above the window is set
  assign zero_mask     = {`MAC_ACC_W{1'b1}} << (chk_shift + `MAC_OUT_W);
  assign fits_unsigned = !tc && ((acc & zero_mask) == '0);

  assign fits = fits_signed || fits_unsigned;

  // unsigned overflow clamps to all ones
  // signed overflow clamps towards the sign of the whole accumulator
  always_comb begin
    if (!tc) begin
      clamp_word = '1;
    end else if (acc[`MAC_ACC_W-1]) begin
      clamp_word = {1'b1, {(`MAC_OUT_W-1){1'b0}}};
    end else begin
      clamp_word = {1'b0, {(`MAC_OUT_W-1){1'b1}}};
    end
  end

  // without saturation the window wraps silently
  assign mac_out = (acc_sat && !fits) ? clamp_word : window;

  // with the clamp on in signed mode the output shows the sign of the whole accumulator
  // this ties the window shift to the shift used by the range check
  a_sat_sign : assert property (
    @(posedge MAC_ACC_CLK) disable iff (!acc_ff_rstn)
    (acc_sat && tc) |-> (mac_out[`MAC_OUT_W-1] == acc[`MAC_ACC_W-1])
  ) else $error("saturated signed output has the wrong sign");

endmodule

`default_nettype wire

//--- hdl/mac_top.sv
// 32-bit multiply-accumulate with an 80-bit accumulator, one cycle latency
// tc and acc_sat also act combinationally on mac_out
`timescale 1ns/1ps
`default_nettype none

module mac_top (
  input  wire logic           MAC_ACC_CLK,
  input  wire logic           acc_ff_rstn,
  input  wire logic           clk_en,
  input  wire mac_pkg::oper_t oper_data,
  input  wire mac_pkg::oper_t coef_data,
  input  wire logic           acc_rnd,
  input  wire logic           acc_clear,
  input  wire logic           acc_sat,
  input  wire mac_pkg::sel_t  out_sel,
  input  wire logic           tc,
  output mac_pkg::out_t       mac_out
);

  // feedback loop between the adder and the register
  mac_pkg::acc_t sum;
  mac_pkg::acc_t addend;

  // registered accumulator seen by the output stage
  mac_pkg::acc_t acc;

  mac_multiply_add u_mac_multiply_add (
    .oper_data (oper_data),
    .coef_data (coef_data),
    .tc        (tc),
    .addend    (addend),
    .sum       (sum)
  );

  // the register also picks the addend, so clear and round stay in one place
  mac_acc_register u_mac_acc_register (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .acc_clear   (acc_clear),
    .acc_rnd     (acc_rnd),
    .out_sel     (out_sel),
    .sum         (sum),
    .addend      (addend),
    .acc         (acc)
  );

  mac_output_stage u_mac_output_stage (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .out_sel     (out_sel),
    .acc         (acc),
    .tc          (tc),
    .acc_sat     (acc_sat),
    .mac_out     (mac_out)
  );

endmodule

`default_nettype wire

//--- verification/tb_mac_model.svh
// reference model of the MAC, meant to be included inside the testbench module
// it reads the testbench input signals directly and keeps its own acc and sel_q
`ifndef TB_MAC_MODEL_SVH
`define TB_MAC_MODEL_SVH

`include "mac_consts.svh"

// model state, the same two registers the design keeps
mac_pkg::acc_t m_acc;
mac_pkg::sel_t m_sel_q;

// widen an operand straight to accumulator width
// modulo 2**80 the product of two widened values equals the exact product
function automatic mac_pkg::acc_t widen_oper(input mac_pkg::oper_t x, input logic tc_in);
  mac_pkg::acc_t w;
  w = '0;
  w[`MAC_OPER_W-1:0] = x;
  if (tc_in && x[`MAC_OPER_W-1]) begin
    w[`MAC_ACC_W-1:`MAC_OPER_W] = '1;
  end
  return w;
endfunction

// restart priority is clear, then round, then the running sum
function automatic mac_pkg::acc_t model_addend(input logic clr, input logic rnd,
                                               input mac_pkg::sel_t sel,
                                               input mac_pkg::acc_t a);
  mac_pkg::acc_t r;
  r = '0;
  if (!clr && rnd && sel >= 1 && sel <= `MAC_SEL_MAX) begin
    r[sel-1] = 1'b1;
  end else if (!clr && !rnd) begin
    r = a;
  end
  return r;
endfunction

// bit by bit extraction of the 32-bit window
function automatic mac_pkg::out_t model_window(input mac_pkg::acc_t a, input mac_pkg::sel_t sel);
  mac_pkg::out_t w;
  int s;
  s = (sel > `MAC_SEL_MAX) ? 0 : int'(sel);
  for (int i = 0; i < `MAC_OUT_W; i++) begin
    w[i] = a[s+i];
  end
  return w;
endfunction

// the window fits if everything from its MSB upward agrees
// in unsigned mode an all-zero region above the window is enough
function automatic logic model_fits(input mac_pkg::acc_t a, input mac_pkg::sel_t sel,
                                    input logic tc_in);
  int   s;
  logic all_one;
  logic all_zero;
  logic upper_zero;
  s = (sel > `MAC_SAT_SEL_MAX) ? 0 : int'(sel);
  all_one = 1'b1;
  all_zero = 1'b1;
  upper_zero = 1'b1;
  for (int b = s + `MAC_OUT_W - 1; b < `MAC_ACC_W; b++) begin
    if (a[b]) begin
      all_zero = 1'b0;
    end else begin
      all_one = 1'b0;
    end
    if (b >= s + `MAC_OUT_W && a[b]) begin
      upper_zero = 1'b0;
    end
  end
  return all_one || all_zero || (!tc_in && upper_zero);
endfunction

// expected mac_out for the model state and the live tc and acc_sat
function automatic mac_pkg::out_t expected_out(input logic tc_in, input logic sat_in);
  if (!sat_in || model_fits(m_acc, m_sel_q, tc_in)) begin
    return model_window(m_acc, m_sel_q);
  end else if (!tc_in) begin
    return 32'hFFFF_FFFF;
  end else if (m_acc[`MAC_ACC_W-1]) begin
    return 32'h8000_0000;
  end
  return 32'h7FFF_FFFF;
endfunction

// one rising edge of the model, using the inputs held before the edge
task automatic advance_model();
  mac_pkg::acc_t prod;
  if (!acc_ff_rstn) begin
    m_acc = '0;
    m_sel_q = '0;
  end else begin
    prod = widen_oper(oper_data, tc) * widen_oper(coef_data, tc);
    if (clk_en) begin
      m_acc = prod + model_addend(acc_clear, acc_rnd, out_sel, m_acc);
    end
    m_sel_q = out_sel;
  end
endtask

// compare one output word, stop at the first mismatch
task automatic check_out(input string phase, input mac_pkg::out_t expected,
                         input mac_pkg::out_t actual);
  if (actual !== expected) begin
    $display("ERROR %s expected %h actual %h", phase, expected, actual);
    $display("Test FAILED");
    $fatal(1, "mac_out mismatch at time %0t", $time);
  end
endtask

`endif

//--- verification/tb_mac_top.sv
// random testbench for the MAC, checked every cycle against a behavioural model
// inputs change on the rising edge, mac_out is compared on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_mac_top;

  localparam int PHASE_LEN   = 500;
  localparam int CYCLE_LIMIT = 6 * PHASE_LEN + 100;

  logic          MAC_ACC_CLK;
  logic          acc_ff_rstn;
  logic          clk_en;
  mac_pkg::oper_t oper_data;
  mac_pkg::oper_t coef_data;
  logic          acc_rnd;
  logic          acc_clear;
  logic          acc_sat;
  mac_pkg::sel_t out_sel;
  logic          tc;
  mac_pkg::out_t mac_out;
  int            cycle_count;

  `include "tb_mac_model.svh"

  mac_top u_mac_top (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .oper_data   (oper_data),
    .coef_data   (coef_data),
    .acc_rnd     (acc_rnd),
    .acc_clear   (acc_clear),
    .acc_sat     (acc_sat),
    .out_sel     (out_sel),
    .tc          (tc),
    .mac_out     (mac_out)
  );

  initial begin
    MAC_ACC_CLK = 1'b0;
    forever #10 MAC_ACC_CLK = ~MAC_ACC_CLK;
  end

  // window selects weighted towards the corners of the range check
  function automatic mac_pkg::sel_t pick_edge_sel();
    case ($urandom_range(0, 7))
      0: return 6'd0;
      1: return 6'd47;
      2: return 6'd48;
      3: return 6'd49 + $urandom_range(0, 14);
      4: return 6'd31 + $urandom_range(0, 1);
      default: return $urandom_range(0, 63);
    endcase
  endfunction

  // operands near the ends of both number ranges
  function automatic mac_pkg::oper_t pick_big_oper();
    case ($urandom_range(0, 4))
      0: return 32'hFFFF_FFFF;
      1: return 32'h8000_0000;
      2: return 32'h7FFF_FFFF;
      3: return {1'b1, 31'($urandom)};
      default: return $urandom;
    endcase
  endfunction

  // rising edge, model step, then the caller drives new inputs
  task automatic edge_update();
    @(posedge MAC_ACC_CLK);
    advance_model();
  endtask

  task automatic settle_and_check(input string phase);
    @(negedge MAC_ACC_CLK);
    check_out(phase, expected_out(tc, acc_sat), mac_out);
  endtask

  // plain accumulation, saturation off, occasional clear
  task automatic run_accumulate(input string phase, input logic tc_val);
    for (int i = 0; i < PHASE_LEN; i++) begin
      edge_update();
      tc <= tc_val;
      acc_sat <= 1'b0;
      acc_rnd <= 1'b0;
      clk_en <= ($urandom_range(0, 3) != 0);
      acc_clear <= ($urandom_range(0, 15) == 0);
      oper_data <= $urandom;
      coef_data <= $urandom;
      out_sel <= $urandom_range(0, 63);
      settle_and_check(phase);
    end
  endtask

  // round pulses over the valid selects, sometimes with clear on top
  task automatic run_round(input string phase);
    for (int i = 0; i < PHASE_LEN; i++) begin
      edge_update();
      tc <= $urandom_range(0, 1);
      acc_sat <= $urandom_range(0, 1);
      clk_en <= ($urandom_range(0, 7) != 0);
      acc_rnd <= ($urandom_range(0, 3) == 0);
      acc_clear <= ($urandom_range(0, 7) == 0);
      oper_data <= $urandom_range(0, 65535);
      coef_data <= $urandom;
      if ($urandom_range(0, 9) == 0) begin
        out_sel <= $urandom_range(0, 63);
      end else begin
        out_sel <= $urandom_range(1, 48);
      end
      settle_and_check(phase);
    end
  endtask

  // large sums with the clamp enabled most of the time
  task automatic run_saturate(input string phase);
    for (int i = 0; i < PHASE_LEN; i++) begin
      edge_update();
      tc <= $urandom_range(0, 1);
      acc_sat <= ($urandom_range(0, 7) != 0);
      clk_en <= ($urandom_range(0, 7) != 0);
      acc_rnd <= ($urandom_range(0, 15) == 0);
      acc_clear <= ($urandom_range(0, 9) == 0);
      oper_data <= pick_big_oper();
      coef_data <= pick_big_oper();
      out_sel <= pick_edge_sel();
      settle_and_check(phase);
    end
  endtask

  // clk_en only pulses once in a long while
  // the window still follows out_sel one edge later during the hold
  task automatic run_hold(input string phase);
    for (int i = 0; i < PHASE_LEN; i++) begin
      edge_update();
      clk_en <= (i % 50 == 49);
      acc_clear <= ($urandom_range(0, 7) == 0);
      acc_rnd <= ($urandom_range(0, 7) == 0);
      oper_data <= pick_big_oper();
      coef_data <= $urandom;
      if (i % 7 == 0) begin
        out_sel <= pick_edge_sel();
        tc <= $urandom_range(0, 1);
        acc_sat <= $urandom_range(0, 1);
      end
      settle_and_check(phase);
    end
  endtask

  // watchdog over the whole run
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge MAC_ACC_CLK);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("Test FAILED");
    $fatal(1, "simulation stopped by the cycle limit");
  end

  initial begin
    void'($urandom(32'h259ae1c6));
    acc_ff_rstn = 1'b0;
    clk_en = 1'b0;
    oper_data = '0;
    coef_data = '0;
    acc_rnd = 1'b0;
    acc_clear = 1'b0;
    acc_sat = 1'b0;
    out_sel = '0;
    tc = 1'b0;
    m_acc = '0;
    m_sel_q = '0;

    // reset is released on the third rising edge
    for (int i = 0; i < 3; i++) begin
      edge_update();
      if (i == 2) begin
        acc_ff_rstn <= 1'b1;
      end
      settle_and_check("reset");
    end

    // no enabled edge yet, so the output must stay at zero
    for (int i = 0; i < 10; i++) begin
      edge_update();
      oper_data <= $urandom;
      coef_data <= $urandom;
      out_sel <= $urandom_range(0, 63);
      tc <= $urandom_range(0, 1);
      settle_and_check("after_reset");
      check_out("after_reset", '0, mac_out);
    end

    run_accumulate("unsigned_acc", 1'b0);
    run_accumulate("signed_acc", 1'b1);
    run_round("round_preload");
    run_saturate("saturation");
    run_hold("hold");

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
+incdir+verification
hdl/mac_pkg.sv
hdl/mac_multiply_add.sv
hdl/mac_acc_register.sv
hdl/mac_output_stage.sv
hdl/mac_top.sv
verification/tb_mac_top.sv
